// File: Bender.yml
package:
  name: tama_core

export_include_dirs:
  - include

sources:
  # packages first, then the RTL blocks and the top level
  - logic/bridge_pkg.sv
  - logic/core_pkg.sv
  - logic/settings_regs.sv
  - logic/clock_enable_gen.sv
  - logic/cpu_run_ctrl.sv
  - logic/rom_store.sv
  - logic/tama_core.sv
  - target: test
    files:
      - tb/tb_tama_core.sv

// File: compile.f
+incdir+include
logic/bridge_pkg.sv
logic/core_pkg.sv
logic/settings_regs.sv
logic/clock_enable_gen.sv
logic/cpu_run_ctrl.sv
logic/rom_store.sv
logic/tama_core.sv
tb/tb_tama_core.sv

// File: include/tama_consts.svh
// Shared constants for the pet CPU timing shell.
// Include wherever a divider reload, width or bridge address is needed.

`ifndef TAMA_CONSTS_SVH
`define TAMA_CONSTS_SVH

////////////////////////////////////////////////////////////
// cpu clock divider reloads
`define TAMA_DIV_W          12
`define TAMA_BASE_DIV       3600
`define TAMA_DIV_4X         900
`define TAMA_DIV_50X        72

// soft reset length in system cycles, kept short for simulation
`define TAMA_RESET_DELAY    16
// dbl ticks held in reset after a save-state load
`define TAMA_SS_RESET_TICKS 3'd4

////////////////////////////////////////////////////////////
// program rom
`define TAMA_ROM_AW         13
`define TAMA_ROM_DEPTH      8192
`define TAMA_ROM_DW         16
`define TAMA_ROM_QW         12
`define TAMA_SLOT_W         16

// mono audio sample, buzzer fills the low bits
`define TAMA_AUDIO_W        15
`define TAMA_AUDIO_LEVEL_W  13

////////////////////////////////////////////////////////////
// host bridge
`define TAMA_BRIDGE_W       32
`define TAMA_ADDR_RESET     32'h0000_0000
`define TAMA_ADDR_SOUND     32'h0000_0010
`define TAMA_ADDR_TURBO     32'h0000_0100
`define TAMA_ADDR_CANCEL    32'h0000_0104

`endif

// File: logic/bridge_pkg.sv
// Host bridge types: the write request bundle and the settings
// register map. Referenced by scoped name from the settings block
// and the top level.

`include "tama_consts.svh"

package bridge_pkg;

  // one write strobe with address and data, no back-pressure
  typedef struct packed {
    logic                      wr;
    logic [`TAMA_BRIDGE_W-1:0] addr;
    logic [`TAMA_BRIDGE_W-1:0] wr_data;
  } bridge_req_t;

  ////////////////////////////////////////////////////////////
  // settings register addresses
  typedef enum logic [`TAMA_BRIDGE_W-1:0] {
    // soft reset trigger, any data
    REG_RESET  = `TAMA_ADDR_RESET,
    // bit 0 mutes the buzzer
    REG_SOUND  = `TAMA_ADDR_SOUND,
    // bits 1:0 select the speed, readable
    REG_TURBO  = `TAMA_ADDR_TURBO,
    // bit 0 drops turbo when the buzzer sounds
    REG_CANCEL = `TAMA_ADDR_CANCEL
  } bridge_reg_e;

endpackage

// File: logic/clock_enable_gen.sv
// CPU clock-enable divider.
// A reloadable down-counter gives the base enable at zero and an
// extra dbl enable at the latched half point.

`timescale 1ns/1ps
`include "tama_consts.svh"

module clock_enable_gen (
  input  logic              clk_sys_117_964,
  input  logic              reset_turbo_s,
  input  core_pkg::turbo_e  turbo,
  output core_pkg::clk_en_t clk_en
);

  logic [`TAMA_DIV_W-1:0] div_cnt;
  logic [`TAMA_DIV_W-1:0] div_half;
  logic [`TAMA_DIV_W-1:0] reload;

  // reload picked by the current speed
  always_comb begin
    case (turbo)
      core_pkg::TURBO_1X:  reload = `TAMA_DIV_W'(`TAMA_BASE_DIV);
      core_pkg::TURBO_4X:  reload = `TAMA_DIV_W'(`TAMA_DIV_4X);
      core_pkg::TURBO_50X: reload = `TAMA_DIV_W'(`TAMA_DIV_50X);
      default:             reload = `TAMA_DIV_W'(1);
    endcase
  end

  ////////////////////////////////////////////////////////////
  // divider
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      div_cnt  <= `TAMA_DIV_W'(`TAMA_BASE_DIV);
      div_half <= `TAMA_DIV_W'(`TAMA_BASE_DIV / 2);
      clk_en   <= '0;
    end else begin
      clk_en <= '0;
      if (div_cnt == '0) begin
        div_cnt <= reload;
        // half point latched with the reload so a speed change
        // mid-period cannot drop or double a dbl tick
        div_half <= (reload == `TAMA_DIV_W'(1)) ? `TAMA_DIV_W'(1) : (reload >> 1);
        clk_en.base <= 1'b1;
        clk_en.dbl  <= 1'b1;
      end else begin
        div_cnt <= div_cnt - 1'b1;
        if (div_cnt == div_half) begin
          clk_en.dbl <= 1'b1;
        end
      end
    end
  end

  assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    clk_en.base |-> clk_en.dbl)
    else $error("base enable without dbl enable");

endmodule

// File: logic/core_pkg.sv
// CPU side types: turbo speed, the clock-enable pair and the
// program ROM load bundle. Referenced by scoped name only.

`include "tama_consts.svh"

package core_pkg;

  // speed code as written over the bridge
  typedef enum logic [1:0] {
    TURBO_1X   = 2'd0,
    TURBO_4X   = 2'd1,
    TURBO_50X  = 2'd2,
    // divider reload of 1, as fast as the divider runs
    TURBO_FULL = 2'd3
  } turbo_e;

  ////////////////////////////////////////////////////////////
  // cpu enables, dbl runs at twice the base rate
  typedef struct packed {
    logic base;
    logic dbl;
  } clk_en_t;

  // one rom word from the data slot loader
  typedef struct packed {
    logic                     en;
    logic [`TAMA_SLOT_W-1:0]  slot_id;
    logic [`TAMA_ROM_AW-1:0]  word_addr;
    logic [`TAMA_ROM_DW-1:0]  data;
  } rom_load_t;

endpackage

// File: logic/cpu_run_ctrl.sv
// CPU run control.
// Merges the reset sources, holds reset for a few dbl ticks after a
// save-state load and blocks the enables while halted.

`timescale 1ns/1ps
`include "tama_consts.svh"

module cpu_run_ctrl (
  input  logic              clk_sys_117_964,
  input  logic              reset_turbo_s,
  input  core_pkg::clk_en_t clk_en,
  input  logic              soft_reset,
  input  logic              ss_begin_reset,
  input  logic              ss_halt,
  output core_pkg::clk_en_t cpu_clk_en,
  output logic              cpu_reset
);

  logic [2:0] ss_cnt;

  // save-state reset tick counter
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      ss_cnt <= '0;
    end else if (ss_begin_reset) begin
      ss_cnt <= `TAMA_SS_RESET_TICKS;
    end else if (ss_cnt != '0 && clk_en.dbl) begin
      // counts the divider ticks, halt does not stop it
      ss_cnt <= ss_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs to the cpu
  assign cpu_clk_en.base = clk_en.base & ~ss_halt;
  assign cpu_clk_en.dbl  = clk_en.dbl & ~ss_halt;

  assign cpu_reset = soft_reset | (ss_cnt != '0) | reset_turbo_s;

  assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    ss_cnt <= `TAMA_SS_RESET_TICKS)
    else $error("save-state reset counter out of range");

endmodule

// File: logic/rom_store.sv
// Program ROM for the pet CPU.
// Loaded word by word from data slot 0, stored byte-swapped, read
// back as 12-bit instructions one cycle after the address.

`timescale 1ns/1ps
`include "tama_consts.svh"

module rom_store (
  input  logic                     clk_sys_117_964,
  input  core_pkg::rom_load_t      rom_load,
  input  logic [`TAMA_ROM_AW-1:0]  rom_addr,
  output logic [`TAMA_ROM_QW-1:0]  rom_data
);

  logic [`TAMA_ROM_DW-1:0] mem [`TAMA_ROM_DEPTH];
  logic                    load_hit;

  // other slots carry images, not program
  assign load_hit = rom_load.en && (rom_load.slot_id == '0);

  ////////////////////////////////////////////////////////////
  // load port, bridge data arrives big endian
  always_ff @(posedge clk_sys_117_964) begin
    if (load_hit) begin
      mem[rom_load.word_addr] <= {rom_load.data[7:0], rom_load.data[15:8]};
    end
  end

  // read port
  always_ff @(posedge clk_sys_117_964) begin
    rom_data <= mem[rom_addr][`TAMA_ROM_QW-1:0];
  end

endmodule

// File: logic/settings_regs.sv
// Bridge-written settings bank for the pet core.
// Holds sound, turbo and cancel bits, runs the soft reset countdown
// and forms the mono audio sample from the buzzer.

`timescale 1ns/1ps
`include "tama_consts.svh"

module settings_regs (
  input  logic                      clk_sys_117_964,
  input  logic                      reset_turbo_s,
  input  bridge_pkg::bridge_req_t   bridge_req,
  input  logic [`TAMA_BRIDGE_W-1:0] bridge_rd_addr,
  output logic [`TAMA_BRIDGE_W-1:0] bridge_rd_data,
  input  logic                      buzzer,
  output core_pkg::turbo_e          turbo,
  output logic                      soft_reset,
  output logic [`TAMA_AUDIO_W-1:0]  audio_sample
);

  logic [`TAMA_BRIDGE_W-1:0] reset_cnt;
  logic                      sound_off;
  logic                      cancel_on_buzz;

  ////////////////////////////////////////////////////////////
  // register writes and countdown
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      reset_cnt      <= '0;
      sound_off      <= 1'b0;
      turbo          <= core_pkg::TURBO_1X;
      cancel_on_buzz <= 1'b0;
    end else begin
      if (reset_cnt != '0) begin
        reset_cnt <= reset_cnt - 1'b1;
      end
      if (bridge_req.wr) begin
        case (bridge_req.addr)
          bridge_pkg::REG_RESET:  reset_cnt <= `TAMA_RESET_DELAY;
          bridge_pkg::REG_SOUND:  sound_off <= bridge_req.wr_data[0];
          bridge_pkg::REG_TURBO:  turbo <= core_pkg::turbo_e'(bridge_req.wr_data[1:0]);
          bridge_pkg::REG_CANCEL: cancel_on_buzz <= bridge_req.wr_data[0];
          default: ;
        endcase
      end
      // buzzer event wins over a turbo write in the same cycle
      if (cancel_on_buzz && buzzer) begin
        turbo <= core_pkg::TURBO_1X;
      end
    end
  end

  assign soft_reset = (reset_cnt != '0);

  // only the turbo setting reads back
  always_comb begin
    case (bridge_rd_addr)
      bridge_pkg::REG_TURBO: bridge_rd_data = {{(`TAMA_BRIDGE_W-2){1'b0}}, turbo};
      default:               bridge_rd_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // audio sample, square wave straight from the buzzer
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s || sound_off) begin
      audio_sample <= '0;
    end else begin
      audio_sample <= {{(`TAMA_AUDIO_W-`TAMA_AUDIO_LEVEL_W){1'b0}},
                       {`TAMA_AUDIO_LEVEL_W{buzzer}}};
    end
  end

  // countdown only ever loads the delay and counts down from it
  assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    reset_cnt <= `TAMA_RESET_DELAY)
    else $error("soft reset countdown above its load value");

endmodule

// File: logic/tama_core.sv
// Timing and control shell around the pet CPU.
// Connects the settings bank, the enable divider, the run control
// and the program ROM. The CPU itself sits outside this block.

`timescale 1ns/1ps
`include "tama_consts.svh"

module tama_core (
  input  logic                      clk_sys_117_964,
  input  logic                      reset_turbo_s,
  // host bridge
  input  bridge_pkg::bridge_req_t   bridge_req,
  input  logic [`TAMA_BRIDGE_W-1:0] bridge_rd_addr,
  output logic [`TAMA_BRIDGE_W-1:0] bridge_rd_data,
  // cpu side
  input  logic                      buzzer,
  input  logic                      ss_begin_reset,
  input  logic                      ss_halt,
  input  core_pkg::rom_load_t       rom_load,
  input  logic [`TAMA_ROM_AW-1:0]   rom_addr,
  output logic [`TAMA_ROM_QW-1:0]   rom_data,
  output core_pkg::clk_en_t         cpu_clk_en,
  output logic                      cpu_reset,
  output logic [`TAMA_AUDIO_W-1:0]  audio_sample
);

  core_pkg::turbo_e  turbo;
  core_pkg::clk_en_t div_clk_en;
  logic              soft_reset;

  ////////////////////////////////////////////////////////////
  // settings and audio
  settings_regs u_settings_regs (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .bridge_req      (bridge_req),
    .bridge_rd_addr  (bridge_rd_addr),
    .bridge_rd_data  (bridge_rd_data),
    .buzzer          (buzzer),
    .turbo           (turbo),
    .soft_reset      (soft_reset),
    .audio_sample    (audio_sample)
  );

  ////////////////////////////////////////////////////////////
  // cpu timing
  clock_enable_gen u_clock_enable_gen (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .turbo           (turbo),
    .clk_en          (div_clk_en)
  );

  cpu_run_ctrl u_cpu_run_ctrl (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .clk_en          (div_clk_en),
    .soft_reset      (soft_reset),
    .ss_begin_reset  (ss_begin_reset),
    .ss_halt         (ss_halt),
    .cpu_clk_en      (cpu_clk_en),
    .cpu_reset       (cpu_reset)
  );

  // program memory
  rom_store u_rom_store (
    .clk_sys_117_964 (clk_sys_117_964),
    .rom_load        (rom_load),
    .rom_addr        (rom_addr),
    .rom_data        (rom_data)
  );

endmodule

// File: tb/tb_tama_core.sv
// Testbench for the pet CPU timing shell.
// Applies a table of bridge and ROM steps, then runs directed checks on the
// enable divider, reset sources, halt, turbo cancel and the audio sample.

`timescale 1ns/1ps
`include "tama_consts.svh"

module tb_tama_core;

  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_ROM   = 2'd2;
  localparam int WAIT_LIMIT = 8000;

  // one table entry, addr and data serve both bridge and rom steps
  typedef struct packed {
    logic [1:0]  op;
    logic [15:0] slot;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
  } step_t;

  logic                    clk_sys_117_964;
  logic                    reset_turbo_s;
  bridge_pkg::bridge_req_t bridge_req;
  logic [31:0]             bridge_rd_addr;
  logic [31:0]             bridge_rd_data;
  logic                    buzzer;
  logic                    ss_begin_reset;
  logic                    ss_halt;
  core_pkg::rom_load_t     rom_load;
  logic [12:0]             rom_addr;
  logic [11:0]             rom_data;
  core_pkg::clk_en_t       cpu_clk_en;
  logic                    cpu_reset;
  logic [14:0]             audio_sample;

  step_t steps[$];
  int    errors = 0;
  int    checks = 0;
  event  timeout_ev;

  tama_core dut (.*);

  always #10 clk_sys_117_964 = ~clk_sys_117_964;

  ////////////////////////////////////////////////////////////
  // reference model and reporting
  function automatic logic [11:0] rom_word_model(input logic [15:0] data);
    logic [15:0] swapped;
    swapped = {data[7:0], data[15:8]};
    return swapped[11:0];
  endfunction

  // base pulse spacing is the divider reload plus one
  function automatic int expected_period(input int speed);
    case (speed)
      0:       return `TAMA_BASE_DIV + 1;
      1:       return `TAMA_DIV_4X + 1;
      2:       return `TAMA_DIV_50X + 1;
      default: return 2;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("timeout at %0t: %s within %0d cycles", $time, what, WAIT_LIMIT);
    -> timeout_ev;
    @(timeout_ev);
  endtask

  // ends the run once a wait has given up
  initial begin
    @(timeout_ev);
    finish_run();
  end

  ////////////////////////////////////////////////////////////
  // bus drivers
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_sys_117_964);
    bridge_req.wr      <= 1'b1;
    bridge_req.addr    <= addr;
    bridge_req.wr_data <= data;
    @(posedge clk_sys_117_964);
    bridge_req.wr <= 1'b0;
  endtask

  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] got);
    @(posedge clk_sys_117_964);
    bridge_rd_addr <= addr;
    @(negedge clk_sys_117_964);
    got = bridge_rd_data;
  endtask

  task automatic rom_write_read(input logic [15:0] slot, input logic [12:0] addr,
                                input logic [15:0] data, output logic [11:0] got);
    @(posedge clk_sys_117_964);
    rom_load.en        <= 1'b1;
    rom_load.slot_id   <= slot;
    rom_load.word_addr <= addr;
    rom_load.data      <= data;
    @(posedge clk_sys_117_964);
    rom_load.en <= 1'b0;
    rom_addr    <= addr;
    @(posedge clk_sys_117_964);
    @(negedge clk_sys_117_964);
    got = rom_data;
  endtask

  // cycles from the previous sample point up to the next base pulse
  task automatic wait_base(output int cycles);
    logic hit;
    hit = 1'b0;
    cycles = 0;
    while (!hit && cycles < WAIT_LIMIT) begin
      @(negedge clk_sys_117_964);
      cycles++;
      hit = cpu_clk_en.base;
    end
    if (!hit) abort_on_timeout("cpu_clk_en.base pulse");
  endtask

  // length of the next cpu_reset pulse and the dbl ticks inside it
  task automatic track_reset(output int high_cycles, output int dbl_seen);
    int n;
    n = 0;
    high_cycles = 0;
    dbl_seen = 0;
    @(negedge clk_sys_117_964);
    while (!cpu_reset && n < WAIT_LIMIT) begin
      @(negedge clk_sys_117_964);
      n++;
    end
    if (!cpu_reset) abort_on_timeout("cpu_reset rising");
    while (cpu_reset && high_cycles < WAIT_LIMIT) begin
      high_cycles++;
      if (cpu_clk_en.dbl) dbl_seen++;
      @(negedge clk_sys_117_964);
    end
    if (cpu_reset) abort_on_timeout("cpu_reset falling");
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  task automatic build_steps();
    logic [15:0] data;
    logic [31:0] addr;
    logic [31:0] first_expected;
    first_expected = '0;
    // sound and cancel hold ones so a leak into read-back shows
    steps.push_back({OP_WRITE, 16'd0, `TAMA_ADDR_SOUND, 32'd1, 32'd0});
    steps.push_back({OP_WRITE, 16'd0, `TAMA_ADDR_CANCEL, 32'd1, 32'd0});
    for (int t = 0; t < 4; t++) begin
      steps.push_back({OP_WRITE, 16'd0, `TAMA_ADDR_TURBO, 32'(t), 32'd0});
      steps.push_back({OP_READ, 16'd0, `TAMA_ADDR_TURBO, 32'd0, 32'(t)});
      steps.push_back({OP_READ, 16'd0, `TAMA_ADDR_CANCEL, 32'd0, 32'd0});
      steps.push_back({OP_READ, 16'd0, `TAMA_ADDR_SOUND, 32'd0, 32'd0});
    end
    steps.push_back({OP_WRITE, 16'd0, `TAMA_ADDR_SOUND, 32'd0, 32'd0});
    steps.push_back({OP_WRITE, 16'd0, `TAMA_ADDR_CANCEL, 32'd0, 32'd0});
    steps.push_back({OP_WRITE, 16'd0, `TAMA_ADDR_TURBO, 32'd0, 32'd0});
    for (int i = 0; i < 6; i++) begin
      data = 16'($urandom);
      addr = 32'((i * 1237 + 5) % `TAMA_ROM_DEPTH);
      if (i == 0) first_expected = 32'(rom_word_model(data));
      steps.push_back({OP_ROM, 16'd0, addr, 32'(data), 32'(rom_word_model(data))});
    end
    // other slot must not overwrite word 5
    steps.push_back({OP_ROM, 16'd3, 32'd5, 32'(16'($urandom)), first_expected});
  endtask

  task automatic apply_steps();
    step_t s;
    logic [31:0] rd;
    logic [11:0] q;
    for (int i = 0; i < steps.size(); i++) begin
      s = steps[i];
      case (s.op)
        OP_WRITE: bridge_write(s.addr, s.data);
        OP_READ: begin
          bridge_read(s.addr, rd);
          check("bridge_rd_data", s.expected, rd);
        end
        default: begin
          rom_write_read(s.slot, s.addr[12:0], s.data[15:0], q);
          check("rom_data", s.expected, 32'(q));
        end
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  initial begin
    int gap;
    int width;
    int dbl_seen;
    logic [31:0] rd;
    clk_sys_117_964 = 1'b0;
    reset_turbo_s   = 1'b1;
    bridge_req      = '0;
    bridge_rd_addr  = '0;
    buzzer          = 1'b0;
    ss_begin_reset  = 1'b0;
    ss_halt         = 1'b0;
    rom_load        = '0;
    rom_addr        = '0;
    void'($urandom(89422));
    build_steps();
    repeat (4) @(posedge clk_sys_117_964);
    @(negedge clk_sys_117_964);
    check("cpu_reset", 1, cpu_reset);
    check("cpu_clk_en", 0, cpu_clk_en);
    check("audio_sample", 0, audio_sample);
    @(posedge clk_sys_117_964);
    reset_turbo_s <= 1'b0;
    @(negedge clk_sys_117_964);
    check("cpu_reset", 0, cpu_reset);

    apply_steps();

    // divider period at each speed, new reload applies after a pulse
    for (int t = 0; t < 4; t++) begin
      bridge_write(`TAMA_ADDR_TURBO, 32'(t));
      wait_base(gap);
      wait_base(gap);
      wait_base(gap);
      check("cpu_clk_en.base period", expected_period(t), gap);
    end

    // soft reset then save-state reset at 50x
    bridge_write(`TAMA_ADDR_TURBO, 32'd2);
    bridge_write(`TAMA_ADDR_RESET, 32'd1);
    track_reset(width, dbl_seen);
    check("cpu_reset width", `TAMA_RESET_DELAY, width);
    @(posedge clk_sys_117_964);
    ss_begin_reset <= 1'b1;
    @(posedge clk_sys_117_964);
    ss_begin_reset <= 1'b0;
    track_reset(width, dbl_seen);
    check("cpu_reset dbl ticks", 4, dbl_seen);

    // halt blocks every enable
    @(posedge clk_sys_117_964);
    ss_halt <= 1'b1;
    repeat (200) begin
      @(negedge clk_sys_117_964);
      check("cpu_clk_en.base", 0, cpu_clk_en.base);
      check("cpu_clk_en.dbl", 0, cpu_clk_en.dbl);
    end
    @(posedge clk_sys_117_964);
    ss_halt <= 1'b0;
    wait_base(gap);

    // turbo cancel on buzzer
    bridge_write(`TAMA_ADDR_CANCEL, 32'd1);
    bridge_write(`TAMA_ADDR_TURBO, 32'd2);
    bridge_read(`TAMA_ADDR_TURBO, rd);
    check("bridge_rd_data", 2, rd);
    @(posedge clk_sys_117_964);
    buzzer <= 1'b1;
    @(posedge clk_sys_117_964);
    buzzer <= 1'b0;
    bridge_read(`TAMA_ADDR_TURBO, rd);
    check("bridge_rd_data", 0, rd);
    bridge_write(`TAMA_ADDR_CANCEL, 32'd0);

    // audio follows buzzer one cycle later
    @(posedge clk_sys_117_964);
    buzzer <= 1'b1;
    @(negedge clk_sys_117_964);
    check("audio_sample", 0, audio_sample);
    @(negedge clk_sys_117_964);
    check("audio_sample", {2'b00, {13{1'b1}}}, audio_sample);
    @(posedge clk_sys_117_964);
    buzzer <= 1'b0;
    @(negedge clk_sys_117_964);
    @(negedge clk_sys_117_964);
    check("audio_sample", 0, audio_sample);
    bridge_write(`TAMA_ADDR_SOUND, 32'd1);
    buzzer <= 1'b1;
    repeat (3) begin
      @(negedge clk_sys_117_964);
      check("audio_sample", 0, audio_sample);
    end
    @(posedge clk_sys_117_964);
    buzzer <= 1'b0;
    finish_run();
  end

endmodule
